/* common/dma_pkg.sv */
package dma_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Transfer length in words
  localparam int SIZE_W = 12;

  // Destination tile id
  localparam int DEST_W = 8;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  // Byte address on the local bus
  typedef logic [31:0] addr_t;

  // One data word, also one network flit
  typedef logic [31:0] data_t;

  // Length in words, zero is not a valid request
  typedef logic [SIZE_W-1:0] size_t;

  typedef logic [DEST_W-1:0] dest_t;

  // Marks a header flit in its top nibble
  localparam logic [3:0] HDR_TAG = 4'hA;

  ////////////////////////////////////////
  // State machines
  ////////////////////////////////////////

  // Bus reader
  typedef enum logic [1:0] {
    BB_IDLE = 2'b00,
    BB_DATA = 2'b01,
    BB_WAIT = 2'b10
  } bb_req_state_e;

  // Network packetizer
  typedef enum logic [1:0] {
    PKT_IDLE    = 2'b00,
    PKT_HEAD    = 2'b01,
    PKT_PAYLOAD = 2'b10
  } pkt_state_e;

endpackage

/* design/dma_req_intake.sv */
`timescale 1ns/100ps

module dma_req_intake (
  input  logic           clk,
  input  logic           rst,

  // Incoming transfer request
  input  logic           start_i,
  input  logic           is_l2r_i,
  input  dma_pkg::size_t size_i,
  input  dma_pkg::addr_t laddr_i,
  input  dma_pkg::dest_t dest_i,

  // Completion from the packetizer
  input  logic           pkt_done_i,

  // Accepted request towards reader and packetizer
  output logic           req_start_o,
  output dma_pkg::size_t req_size_o,
  output dma_pkg::addr_t req_laddr_o,
  output dma_pkg::dest_t req_dest_o,
  output logic           busy_o
);

  ////////////////////////////////////////
  // Request filter
  ////////////////////////////////////////

  logic accept;

  // Only local-to-remote, nonzero length, and only while idle
  assign accept = start_i & is_l2r_i & (size_i != '0) & ~busy_o;

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      req_start_o <= 1'b0;
      busy_o      <= 1'b0;
    end else begin
      // One-cycle start pulse after acceptance
      req_start_o <= accept;
      // Busy rises with acceptance, falls after the packet is out
      if (accept) begin
        busy_o <= 1'b1;
      end else if (pkt_done_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  // Request fields, held until the next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      req_size_o  <= size_i;
      req_laddr_o <= laddr_i;
      req_dest_o  <= dest_i;
    end
  end

endmodule

/* initiator/dma_initiator_req_bb.sv */
`timescale 1ns/100ps

module dma_initiator_req_bb (
  input  logic           clk,
  input  logic           rst,

  // Local read bus, fixed one-cycle latency
  output dma_pkg::addr_t bb_req_addr_o,
  output logic           bb_req_en_o,
  input  dma_pkg::data_t bb_req_dout_i,

  // Accepted request
  input  logic           req_start_i,
  input  dma_pkg::size_t req_size_i,
  input  dma_pkg::addr_t req_laddr_i,

  // FIFO head towards the packetizer
  output logic           req_data_valid_o,
  output dma_pkg::data_t req_data_o,
  input  logic           req_data_ready_i
);

  ////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////

  dma_pkg::bb_req_state_e state;
  dma_pkg::bb_req_state_e nxt_state;

  // Words issued so far
  dma_pkg::size_t count;
  dma_pkg::size_t nxt_count;

  // Last word of the transfer is being issued
  logic last_read;

  // Registered bus enable marks valid read data
  logic bus_en_q;

  // Three entries, entry 0 is the head
  dma_pkg::data_t fifo_mem [0:2];

  // One-hot fill level, bit 0 empty up to bit 3 full
  logic [3:0] fifo_pos;

  logic fifo_push;
  logic fifo_pop;
  logic fifo_empty;

  // Fewer than two entries stored
  logic data_fifo_ready;

  ////////////////////////////////////////
  // Decoupling FIFO
  ////////////////////////////////////////

  assign fifo_empty      = fifo_pos[0];
  assign data_fifo_ready = fifo_pos[0] | fifo_pos[1];

  // Returned word arrives one cycle after the enabled cycle
  assign fifo_push = bus_en_q;
  assign fifo_pop  = req_data_ready_i & ~fifo_empty;

  assign req_data_valid_o = ~fifo_empty;
  assign req_data_o       = fifo_mem[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_pos <= 4'b0001;
      bus_en_q <= 1'b0;
    end else begin
      bus_en_q <= bb_req_en_o;
      // Push and pop together keep the level
      if (fifo_push & ~fifo_pop) begin
        fifo_pos <= fifo_pos << 1;
      end else if (fifo_pop & ~fifo_push) begin
        fifo_pos <= fifo_pos >> 1;
      end
    end
  end

  // Shift towards the head on pop, write at the fill position on push
  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (fifo_pop) begin
        if (fifo_push & fifo_pos[i+1]) begin
          // Slot freed by the shift takes the new word
          fifo_mem[i] <= bb_req_dout_i;
        end else if (i < 2) begin
          fifo_mem[i] <= fifo_mem[i+1];
        end
      end else if (fifo_push & fifo_pos[i]) begin
        fifo_mem[i] <= bb_req_dout_i;
      end
    end
  end

  ////////////////////////////////////////
  // Read state machine
  ////////////////////////////////////////

  assign last_read = (count == dma_pkg::size_t'(req_size_i - 1'b1));

  // Base address plus four bytes per word
  assign bb_req_addr_o = req_laddr_i + (dma_pkg::addr_t'(count) << 2);

  always_comb begin
    nxt_state   = state;
    nxt_count   = count;
    bb_req_en_o = 1'b0;

    case (state)
      dma_pkg::BB_IDLE: begin
        nxt_count = '0;
        // FIFO is empty here, so reads start at once
        if (req_start_i) begin
          nxt_state = dma_pkg::BB_DATA;
        end
      end
      dma_pkg::BB_DATA: begin
        if (data_fifo_ready) begin
          // One read per cycle
          bb_req_en_o = 1'b1;
          nxt_count   = count + 1'b1;
          // Its word still gets pushed next cycle
          if (last_read) begin
            nxt_state = dma_pkg::BB_IDLE;
          end
        end else begin
          // High-water reached, keep room for the word in flight
          nxt_state = dma_pkg::BB_WAIT;
        end
      end
      dma_pkg::BB_WAIT: begin
        if (data_fifo_ready) begin
          nxt_state = dma_pkg::BB_DATA;
        end
      end
      default: begin
        nxt_state = dma_pkg::BB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dma_pkg::BB_IDLE;
      count <= '0;
    end else begin
      state <= nxt_state;
      count <= nxt_count;
    end
  end

endmodule

/* design/dma_local_ram.sv */
`timescale 1ns/100ps

module dma_local_ram #(
  parameter int RAM_AW = 10
) (
  input  logic              clk,

  // Read port from the bus reader
  input  logic              bus_en_i,
  input  dma_pkg::addr_t    bus_addr_i,
  output dma_pkg::data_t    bus_rdata_o,

  // Preload port, word address
  input  logic              pre_we_i,
  input  logic [RAM_AW-1:0] pre_addr_i,
  input  dma_pkg::data_t    pre_wdata_i
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  dma_pkg::data_t mem [0:(2**RAM_AW)-1];

  // Byte address to word index
  logic [RAM_AW-1:0] rd_word;

  assign rd_word = bus_addr_i[RAM_AW+1:2];

  ////////////////////////////////////////
  // Ports
  ////////////////////////////////////////

  // Data returns one cycle after an enabled cycle
  always_ff @(posedge clk) begin
    if (bus_en_i) begin
      bus_rdata_o <= mem[rd_word];
    end
  end

  // One preload word per cycle
  always_ff @(posedge clk) begin
    if (pre_we_i) begin
      mem[pre_addr_i] <= pre_wdata_i;
    end
  end

endmodule

/* design/dma_noc_packetizer.sv */
`timescale 1ns/100ps

module dma_noc_packetizer (
  input  logic           clk,
  input  logic           rst,

  // Accepted request
  input  logic           req_start_i,
  input  dma_pkg::size_t req_size_i,
  input  dma_pkg::dest_t req_dest_i,

  // FIFO head from the reader
  input  logic           req_data_valid_i,
  input  dma_pkg::data_t req_data_i,
  output logic           req_data_ready_o,

  // Network port
  output logic           noc_valid_o,
  output dma_pkg::data_t noc_flit_o,
  output logic           noc_last_o,
  input  logic           noc_ready_i,

  // Packet completed
  output logic           pkt_done_o
);

  ////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////

  dma_pkg::pkt_state_e state;

  // Number of the payload flit on offer, starting at one
  dma_pkg::size_t flit_cnt;

  dma_pkg::data_t header;
  logic           flit_xfer;

  // Tag, destination, zero byte, size
  assign header = {dma_pkg::HDR_TAG, req_dest_i, 8'h00, req_size_i};

  assign flit_xfer = noc_valid_o & noc_ready_i;

  ////////////////////////////////////////
  // Output muxing
  ////////////////////////////////////////

  always_comb begin
    noc_valid_o      = 1'b0;
    noc_flit_o       = header;
    noc_last_o       = 1'b0;
    req_data_ready_o = 1'b0;

    case (state)
      dma_pkg::PKT_HEAD: begin
        noc_valid_o = 1'b1;
      end
      dma_pkg::PKT_PAYLOAD: begin
        // FIFO head goes straight out, pop only on transfer
        noc_valid_o      = req_data_valid_i;
        noc_flit_o       = req_data_i;
        noc_last_o       = (flit_cnt == req_size_i);
        req_data_ready_o = req_data_valid_i & noc_ready_i;
      end
      default: begin
      end
    endcase
  end

  ////////////////////////////////////////
  // State and flit counter
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= dma_pkg::PKT_IDLE;
      flit_cnt   <= '0;
      pkt_done_o <= 1'b0;
    end else begin
      pkt_done_o <= 1'b0;
      case (state)
        dma_pkg::PKT_IDLE: begin
          if (req_start_i) begin
            state <= dma_pkg::PKT_HEAD;
          end
        end
        dma_pkg::PKT_HEAD: begin
          // Header held until accepted
          if (flit_xfer) begin
            state    <= dma_pkg::PKT_PAYLOAD;
            flit_cnt <= dma_pkg::size_t'(1);
          end
        end
        dma_pkg::PKT_PAYLOAD: begin
          if (flit_xfer) begin
            if (noc_last_o) begin
              pkt_done_o <= 1'b1;
              state      <= dma_pkg::PKT_IDLE;
            end else begin
              flit_cnt <= flit_cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= dma_pkg::PKT_IDLE;
        end
      endcase
    end
  end

endmodule

/* design/dma_l2r_top.sv */
`timescale 1ns/100ps

module dma_l2r_top #(
  parameter int RAM_AW = 10
) (
  input  logic              clk,
  input  logic              rst,

  // Transfer request
  input  logic              start_i,
  input  logic              is_l2r_i,
  input  dma_pkg::size_t    size_i,
  input  dma_pkg::addr_t    laddr_i,
  input  dma_pkg::dest_t    dest_i,
  output logic              busy_o,

  // Memory preload, word address
  input  logic              pre_we_i,
  input  logic [RAM_AW-1:0] pre_addr_i,
  input  dma_pkg::data_t    pre_wdata_i,

  // Network port
  output logic              noc_valid_o,
  output dma_pkg::data_t    noc_flit_o,
  output logic              noc_last_o,
  input  logic              noc_ready_i
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  // Accepted request
  logic           req_start;
  dma_pkg::size_t req_size;
  dma_pkg::addr_t req_laddr;
  dma_pkg::dest_t req_dest;
  logic           pkt_done;

  // Local bus
  logic           bus_en;
  dma_pkg::addr_t bus_addr;
  dma_pkg::data_t bus_rdata;

  // FIFO pop handshake
  logic           req_data_valid;
  dma_pkg::data_t req_data;
  logic           req_data_ready;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  dma_req_intake u_intake (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start_i),
    .is_l2r_i    (is_l2r_i),
    .size_i      (size_i),
    .laddr_i     (laddr_i),
    .dest_i      (dest_i),
    .pkt_done_i  (pkt_done),
    .req_start_o (req_start),
    .req_size_o  (req_size),
    .req_laddr_o (req_laddr),
    .req_dest_o  (req_dest),
    .busy_o      (busy_o)
  );

  dma_initiator_req_bb u_reader (
    .clk              (clk),
    .rst              (rst),
    .bb_req_addr_o    (bus_addr),
    .bb_req_en_o      (bus_en),
    .bb_req_dout_i    (bus_rdata),
    .req_start_i      (req_start),
    .req_size_i       (req_size),
    .req_laddr_i      (req_laddr),
    .req_data_valid_o (req_data_valid),
    .req_data_o       (req_data),
    .req_data_ready_i (req_data_ready)
  );

  dma_local_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .clk         (clk),
    .bus_en_i    (bus_en),
    .bus_addr_i  (bus_addr),
    .bus_rdata_o (bus_rdata),
    .pre_we_i    (pre_we_i),
    .pre_addr_i  (pre_addr_i),
    .pre_wdata_i (pre_wdata_i)
  );

  dma_noc_packetizer u_packetizer (
    .clk              (clk),
    .rst              (rst),
    .req_start_i      (req_start),
    .req_size_i       (req_size),
    .req_dest_i       (req_dest),
    .req_data_valid_i (req_data_valid),
    .req_data_i       (req_data),
    .req_data_ready_o (req_data_ready),
    .noc_valid_o      (noc_valid_o),
    .noc_flit_o       (noc_flit_o),
    .noc_last_o       (noc_last_o),
    .noc_ready_i      (noc_ready_i),
    .pkt_done_o       (pkt_done)
  );

endmodule

/* test/dma_l2r_props.sv */
`timescale 1ns/100ps

module dma_l2r_props (
  input  logic           clk,
  input  logic           rst,
  input  logic           start_i,
  input  logic           is_l2r_i,
  input  dma_pkg::size_t size_i,
  input  logic           busy_o,
  input  logic           noc_valid_o,
  input  dma_pkg::data_t noc_flit_o,
  input  logic           noc_last_o,
  input  logic           noc_ready_i,
  input  logic           bus_en
);

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // A request the intake must take
  logic accept;

  assign accept = start_i && is_l2r_i && (size_i != '0) && !busy_o;

  ////////////////////////////////////////
  // Protocol rules
  ////////////////////////////////////////

  // Port idle once reset has been applied
  reset_idle: assert property (@(posedge clk) rst |=> (!noc_valid_o && !busy_o))
    else begin
      $error("network valid or busy high right after reset");
      fail_count++;
    end

  // Stalled flit holds flit and last flag
  stall_stable: assert property (@(posedge clk) disable iff (rst)
    (noc_valid_o && !noc_ready_i) |=>
      (noc_valid_o && $stable(noc_flit_o) && $stable(noc_last_o)))
    else begin
      $error("flit or last flag changed while the network stalled");
      fail_count++;
    end

  // Header on the port two cycles after acceptance
  head_timing: assert property (@(posedge clk) disable iff (rst)
    $past(accept, 2) |-> (noc_valid_o && noc_flit_o[31:28] == dma_pkg::HDR_TAG))
    else begin
      $error("header flit not valid two cycles after an accepted start");
      fail_count++;
    end

  // Bus reads only belong to a transfer in progress
  read_in_busy: assert property (@(posedge clk) disable iff (rst)
    $rose(bus_en) |-> busy_o)
    else begin
      $error("bus enable rose while the path was idle");
      fail_count++;
    end

endmodule

bind dma_l2r_top dma_l2r_props u_props (
  .clk         (clk),
  .rst         (rst),
  .start_i     (start_i),
  .is_l2r_i    (is_l2r_i),
  .size_i      (size_i),
  .busy_o      (busy_o),
  .noc_valid_o (noc_valid_o),
  .noc_flit_o  (noc_flit_o),
  .noc_last_o  (noc_last_o),
  .noc_ready_i (noc_ready_i),
  .bus_en      (bus_en)
);

/* test/dma_l2r_tb.sv */
`timescale 1ns/100ps

module dma_l2r_tb;

  localparam int RAM_AW      = 10;
  localparam int PRELOAD_N   = 128;
  // Sum of all accepted request lengths below
  localparam int TOTAL_WORDS = 121;
  localparam int TIMEOUT_CYC = 20 * TOTAL_WORDS + 200;

  logic              clk;
  logic              rst;
  logic              start_i;
  logic              is_l2r_i;
  dma_pkg::size_t    size_i;
  dma_pkg::addr_t    laddr_i;
  dma_pkg::dest_t    dest_i;
  logic              busy_o;
  logic              pre_we_i;
  logic [RAM_AW-1:0] pre_addr_i;
  dma_pkg::data_t    pre_wdata_i;
  logic              noc_valid_o;
  dma_pkg::data_t    noc_flit_o;
  logic              noc_last_o;
  logic              noc_ready_i = 1'b1;

  // Scoreboard with one entry per expected flit
  dma_pkg::data_t exp_flit_q [$];
  logic           exp_last_q [$];
  dma_pkg::data_t exp_flit;
  logic           exp_last;

  int          error_count = 0;
  int unsigned prop_errors;
  int          cycle_cnt = 0;
  logic        count_en = 1'b0;
  logic        busy_q = 1'b0;
  logic        bp_mode = 1'b0;
  logic [3:0]  stall_left = '0;
  logic [31:0] rnd_state = 32'h2ccb_53f0;

  dma_l2r_top #(
    .RAM_AW (RAM_AW)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start_i),
    .is_l2r_i    (is_l2r_i),
    .size_i      (size_i),
    .laddr_i     (laddr_i),
    .dest_i      (dest_i),
    .busy_o      (busy_o),
    .pre_we_i    (pre_we_i),
    .pre_addr_i  (pre_addr_i),
    .pre_wdata_i (pre_wdata_i),
    .noc_valid_o (noc_valid_o),
    .noc_flit_o  (noc_flit_o),
    .noc_last_o  (noc_last_o),
    .noc_ready_i (noc_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] got_v);
    $display("CHECK FAILED at %0t: %s expected %h observed %h", $time, name, exp_v, got_v);
    error_count++;
  endtask

  // Header flit followed by words laddr/4 + k of the preload pattern
  task automatic expect_packet(input dma_pkg::size_t size, input dma_pkg::addr_t laddr,
                               input dma_pkg::dest_t dest);
    dma_pkg::data_t base;
    base = 32'h5A00_0000 + (laddr >> 2);
    exp_flit_q.push_back({dma_pkg::HDR_TAG, dest, 8'h00, size});
    exp_last_q.push_back(1'b0);
    for (int k = 0; k < int'(size); k++) begin
      exp_flit_q.push_back(base + k);
      exp_last_q.push_back(k == int'(size) - 1);
    end
  endtask

  // One-cycle start pulse with its request fields
  task automatic pulse_start(input logic l2r, input dma_pkg::size_t size,
                             input dma_pkg::addr_t laddr, input dma_pkg::dest_t dest);
    @(negedge clk);
    start_i  = 1'b1;
    is_l2r_i = l2r;
    size_i   = size;
    laddr_i  = laddr;
    dest_i   = dest;
    @(negedge clk);
    start_i  = 1'b0;
  endtask

  task automatic wait_packet_end();
    while (busy_o || exp_flit_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic run_packet(input dma_pkg::size_t size, input dma_pkg::addr_t laddr,
                            input dma_pkg::dest_t dest);
    expect_packet(size, laddr, dest);
    pulse_start(1'b1, size, laddr, dest);
    assert (busy_o == 1'b1) else report_value("busy_o", 32'd1, {31'b0, busy_o});
    wait_packet_end();
    repeat (2) @(negedge clk);
  endtask

  // Rejected while idle so busy stays low
  task automatic reject_idle(input logic l2r, input dma_pkg::size_t size);
    pulse_start(l2r, size, 32'h0000_0030, 8'h33);
    repeat (4) begin
      assert (busy_o == 1'b0) else report_value("busy_o", 32'd0, {31'b0, busy_o});
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////
  // Ready, monitor and timeout
  ////////////////////////////////////////

  // Random ready with occasional long low stretches
  always @(negedge clk) begin
    if (bp_mode) begin
      rnd_state = xorshift32(rnd_state);
      if (stall_left != 4'd0) begin
        noc_ready_i <= 1'b0;
        stall_left  <= stall_left - 4'd1;
      end else if (rnd_state[7:0] < 8'd20) begin
        noc_ready_i <= 1'b0;
        stall_left  <= rnd_state[11:8];
      end else begin
        noc_ready_i <= rnd_state[16];
      end
    end else begin
      noc_ready_i <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (noc_valid_o && noc_ready_i) begin
        assert (exp_flit_q.size() != 0) else begin
          $display("Flit %h at %0t arrived with no packet pending", noc_flit_o, $time);
          error_count++;
        end
        if (exp_flit_q.size() != 0) begin
          exp_flit = exp_flit_q.pop_front();
          exp_last = exp_last_q.pop_front();
          assert (noc_flit_o == exp_flit) else report_value("noc_flit_o", exp_flit, noc_flit_o);
          assert (noc_last_o == exp_last)
            else report_value("noc_last_o", {31'b0, exp_last}, {31'b0, noc_last_o});
        end
      end
      // Busy drops only once the whole packet is out
      if (busy_q && !busy_o) begin
        assert (exp_flit_q.size() == 0) else begin
          $display("Busy fell at %0t with %0d flits still missing", $time, exp_flit_q.size());
          error_count++;
        end
      end
    end
    busy_q <= busy_o;
  end

  always @(posedge clk) begin
    if (count_en) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
        $display("Timeout, transfers not finished within %0d cycles", TIMEOUT_CYC);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    rst         = 1'b1;
    start_i     = 1'b0;
    is_l2r_i    = 1'b0;
    size_i      = '0;
    laddr_i     = '0;
    dest_i      = '0;
    pre_we_i    = 1'b0;
    pre_addr_i  = '0;
    pre_wdata_i = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Word k holds 0x5A000000 + k
    for (int k = 0; k < PRELOAD_N; k++) begin
      @(negedge clk);
      pre_we_i    = 1'b1;
      pre_addr_i  = RAM_AW'(k);
      pre_wdata_i = 32'h5A00_0000 + k;
    end
    @(negedge clk);
    pre_we_i = 1'b0;
    count_en = 1'b1;

    // Lengths 1, 2, 3, 7 and 40 with ready held high
    run_packet(12'd1, 32'h0000_0000, 8'h11);
    run_packet(12'd2, 32'h0000_0010, 8'h22);
    run_packet(12'd3, 32'h0000_0020, 8'h3C);
    run_packet(12'd7, 32'h0000_0040, 8'h45);
    run_packet(12'd40, 32'h0000_0100, 8'hF0);

    // Back-pressure phase
    bp_mode <= 1'b1;
    run_packet(12'd40, 32'h0000_0060, 8'h01);
    run_packet(12'd7, 32'h0000_00C4, 8'h9A);
    run_packet(12'd13, 32'h0000_0150, 8'hB7);
    bp_mode <= 1'b0;
    repeat (2) @(negedge clk);

    // Wrong direction and zero length
    reject_idle(1'b0, 12'd4);
    reject_idle(1'b1, 12'd0);

    // Second start while the first packet is in progress
    expect_packet(12'd6, 32'h0000_0004, 8'h5C);
    pulse_start(1'b1, 12'd6, 32'h0000_0004, 8'h5C);
    assert (busy_o == 1'b1) else report_value("busy_o", 32'd1, {31'b0, busy_o});
    pulse_start(1'b1, 12'd3, 32'h0000_0080, 8'h66);
    assert (busy_o == 1'b1) else report_value("busy_o", 32'd1, {31'b0, busy_o});
    wait_packet_end();
    // A stray packet would show up as an unexpected flit here
    repeat (10) @(negedge clk);
    assert (busy_o == 1'b0) else report_value("busy_o", 32'd0, {31'b0, busy_o});

    // Normal request after the rejected ones
    run_packet(12'd2, 32'h0000_01F8, 8'h77);

    repeat (5) @(negedge clk);
    prop_errors = uut.u_props.fail_count;
    $display("Errors: %0d check failures, %0d assertion failures", error_count, prop_errors);
    if (error_count == 0 && prop_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
common/dma_pkg.sv
design/dma_req_intake.sv
initiator/dma_initiator_req_bb.sv
design/dma_local_ram.sv
design/dma_noc_packetizer.sv
design/dma_l2r_top.sv
test/dma_l2r_props.sv
test/dma_l2r_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := dma_l2r_tb
FLIST    := flist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
SIM_ARGS := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
